// ==== hdl/graph_cfg.svh ====
/*
 * graphing display configuration
 * raster timing, origin, function scaling, latencies and colours
 */
`ifndef GRAPH_CFG_SVH
`define GRAPH_CFG_SVH

`define GRAPH_CORDW 16        // coordinate width in bits

// 480p horizontal timing, pixels
`define H_ACTIVE 640
`define H_FP     16
`define H_SYNC   96
`define H_BP     48

// 480p vertical timing, lines
`define V_ACTIVE 480
`define V_FP     10
`define V_SYNC   2
`define V_BP     33

// origin in screen space, centre of active area
`define X_OFFS 320
`define Y_OFFS 239

`define FUNC_SHIFT 5          // y = (x*x) >> FUNC_SHIFT

`define FUNC_LAT  2           // func_squared pipeline depth
`define GRAPH_LAT 4           // counters to coloured pixel

// colours, 8 bits per channel
`define COL_AXIS    8'hCC     // grey, all channels
`define COL_CURVE_R 8'h33
`define COL_CURVE_G 8'hBB
`define COL_CURVE_B 8'hCC
`define COL_BG      8'h22     // dark grey, all channels

`endif

// ==== hdl/graph_pkg.sv ====
/*
 * graphing display types
 * shared coordinate and colour channel types
 */
`include "graph_cfg.svh"

package graph_pkg;

    // signed so the plotter can work either side of the origin
    typedef logic signed [`GRAPH_CORDW-1:0] coord_t;

    // one 8-bit colour channel
    typedef logic [7:0] chan_t;

endpackage

// ==== hdl/pipe_delay.sv ====
/*
 * fixed depth delay line
 * any payload type, every stage resets to a given value
 */
module pipe_delay #(
    parameter type      payload_t = logic,
    parameter int       DEPTH     = 2,     // cycles of delay, at least 1
    parameter payload_t RESET_VAL = '0
) (
    input  logic     clk_pix,
    input  logic     arst_n,
    input  payload_t din,
    output payload_t dout
);

    payload_t stage [DEPTH];  // stage 0 takes din

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= RESET_VAL;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];  // shift along
            end
        end
    end

    assign dout = stage[DEPTH-1];  // oldest stage

endmodule

// ==== hdl/display_timing.sv ====
/*
 * display timing generator for 640x480 at 60 Hz
 * walks the raster and produces sync, data enable and frame start
 */
`include "graph_cfg.svh"

module display_timing (
    input  logic            clk_pix,
    input  logic            arst_n,
    output graph_pkg::coord_t sx,     // horizontal position
    output graph_pkg::coord_t sy,     // vertical position
    output logic            hsync,    // active low
    output logic            vsync,    // active low
    output logic            de,       // high in active area
    output logic            frame     // one cycle at (0,0)
);
    import graph_pkg::*;

    // line and frame extents
    localparam int H_TOTAL = `H_ACTIVE + `H_FP + `H_SYNC + `H_BP;  // 800
    localparam int V_TOTAL = `V_ACTIVE + `V_FP + `V_SYNC + `V_BP;  // 525
    localparam int HS_STA  = `H_ACTIVE + `H_FP;                    // sync starts
    localparam int HS_END  = HS_STA + `H_SYNC;                     // first pixel after
    localparam int VS_STA  = `V_ACTIVE + `V_FP;
    localparam int VS_END  = VS_STA + `V_SYNC;

    coord_t x_nxt, y_nxt;  // counter values for the next cycle

    // next position, wraps at end of line and end of frame
    always_comb begin
        x_nxt = sx + coord_t'(1);
        y_nxt = sy;
        if (sx == coord_t'(H_TOTAL - 1)) begin
            x_nxt = '0;
            if (sy == coord_t'(V_TOTAL - 1)) y_nxt = '0;
            else y_nxt = sy + coord_t'(1);
        end
    end

    // flags decoded from next position so they match the registered counters
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx    <= '0;
            sy    <= '0;
            hsync <= 1'b1;  // idle high
            vsync <= 1'b1;
            de    <= 1'b0;
            frame <= 1'b0;
        end else begin
            sx    <= x_nxt;
            sy    <= y_nxt;
            hsync <= !(x_nxt >= coord_t'(HS_STA) && x_nxt < coord_t'(HS_END));
            vsync <= !(y_nxt >= coord_t'(VS_STA) && y_nxt < coord_t'(VS_END));
            de    <= (x_nxt < coord_t'(`H_ACTIVE)) && (y_nxt < coord_t'(`V_ACTIVE));
            frame <= (x_nxt == '0) && (y_nxt == '0);  // start of frame
        end
    end

endmodule

// ==== hdl/func_squared.sv ====
/*
 * squared function test, two pipeline stages
 * r is high when y equals x squared scaled by FUNC_SHIFT
 */
`include "graph_cfg.svh"

module func_squared (
    input  logic              clk_pix,
    input  logic              arst_n,
    input  graph_pkg::coord_t x,
    input  graph_pkg::coord_t y,
    output logic              r      // point lies on the curve
);
    import graph_pkg::*;

    localparam int SQW = 2 * `GRAPH_CORDW;  // full width of the square

    logic [SQW-1:0] sq;    // x*x, never negative
    coord_t         y_d;   // y held to meet sq

    // stage 1: square and hold y
    always_ff @(posedge clk_pix) begin
        sq  <= SQW'(x * x);
        y_d <= y;
    end

    // stage 2: compare against scaled square
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            r <= 1'b0;
        end else begin
            // negative y sits below the curve minimum
            r <= !y_d[`GRAPH_CORDW-1] &&
                 ((sq >> `FUNC_SHIFT) == {{`GRAPH_CORDW{1'b0}}, y_d});
        end
    end

endmodule

// ==== hdl/graph_plotter.sv ====
/*
 * graph plotter, moves the origin to screen centre
 * draws both axes and the squared curve, then picks the pixel colour
 */
`include "graph_cfg.svh"

module graph_plotter (
    input  logic              clk_pix,
    input  logic              arst_n,
    input  graph_pkg::coord_t sx,
    input  graph_pkg::coord_t sy,
    input  logic              de,
    output graph_pkg::chan_t  red,
    output graph_pkg::chan_t  green,
    output graph_pkg::chan_t  blue
);
    import graph_pkg::*;

    localparam int FLAG_LAT = `FUNC_LAT + 1;  // origin register plus function

    coord_t x, y;             // function space, y up
    logic   axis;             // on either axis, screen space
    logic   axis_d, de_d;     // flags aligned to draw
    logic   draw;             // curve hit from func_squared

    // cycle 1: function coordinates
    always_ff @(posedge clk_pix) begin
        x <= sx - coord_t'(`X_OFFS);
        y <= coord_t'(`Y_OFFS) - sy;   // screen y grows downward
    end

    // vertical axis at origin column, horizontal at origin line
    assign axis = (sx == coord_t'(`X_OFFS)) || (sy == coord_t'(`Y_OFFS));

    func_squared func0 (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .x       (x),
        .y       (y),
        .r       (draw)
    );

    pipe_delay #(.payload_t(logic), .DEPTH(FLAG_LAT), .RESET_VAL(1'b0)) axis_dly (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .din     (axis),
        .dout    (axis_d)
    );

    pipe_delay #(.payload_t(logic), .DEPTH(FLAG_LAT), .RESET_VAL(1'b0)) de_dly (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .din     (de),
        .dout    (de_d)
    );

    // colour mux, blanking wins, then axis, then curve
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (!de_d) begin
            red   <= '0;   // black in blanking
            green <= '0;
            blue  <= '0;
        end else if (axis_d) begin
            red   <= chan_t'(`COL_AXIS);
            green <= chan_t'(`COL_AXIS);
            blue  <= chan_t'(`COL_AXIS);
        end else if (draw) begin
            red   <= chan_t'(`COL_CURVE_R);
            green <= chan_t'(`COL_CURVE_G);
            blue  <= chan_t'(`COL_CURVE_B);
        end else begin
            red   <= chan_t'(`COL_BG);
            green <= chan_t'(`COL_BG);
            blue  <= chan_t'(`COL_BG);
        end
    end

endmodule

// ==== hdl/graph_top.sv ====
/*
 * graphing display top
 * timing generator and plotter, with sync and position delayed to match colour
 */
`include "graph_cfg.svh"

module graph_top (
    input  logic              clk_pix,
    input  logic              arst_n,
    output graph_pkg::coord_t sx,
    output graph_pkg::coord_t sy,
    output logic              hsync,
    output logic              vsync,
    output logic              de,
    output logic              frame,
    output graph_pkg::chan_t  red,
    output graph_pkg::chan_t  green,
    output graph_pkg::chan_t  blue
);
    import graph_pkg::*;

    // straight from the counters, GRAPH_LAT ahead of colour
    coord_t sx_t, sy_t;
    logic   hsync_t, vsync_t, de_t, frame_t;

    display_timing timing0 (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .sx      (sx_t),
        .sy      (sy_t),
        .hsync   (hsync_t),
        .vsync   (vsync_t),
        .de      (de_t),
        .frame   (frame_t)
    );

    graph_plotter plot0 (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .sx      (sx_t),
        .sy      (sy_t),
        .de      (de_t),
        .red     (red),
        .green   (green),
        .blue    (blue)
    );

    // position delays
    pipe_delay #(.payload_t(coord_t), .DEPTH(`GRAPH_LAT), .RESET_VAL('0)) sx_dly (
        .clk_pix (clk_pix), .arst_n (arst_n), .din (sx_t), .dout (sx)
    );
    pipe_delay #(.payload_t(coord_t), .DEPTH(`GRAPH_LAT), .RESET_VAL('0)) sy_dly (
        .clk_pix (clk_pix), .arst_n (arst_n), .din (sy_t), .dout (sy)
    );

    // strobes, idle low
    pipe_delay #(.payload_t(logic), .DEPTH(`GRAPH_LAT), .RESET_VAL(1'b0)) de_dly (
        .clk_pix (clk_pix), .arst_n (arst_n), .din (de_t), .dout (de)
    );
    pipe_delay #(.payload_t(logic), .DEPTH(`GRAPH_LAT), .RESET_VAL(1'b0)) frame_dly (
        .clk_pix (clk_pix), .arst_n (arst_n), .din (frame_t), .dout (frame)
    );

    // syncs are active low, so idle high
    pipe_delay #(.payload_t(logic), .DEPTH(`GRAPH_LAT), .RESET_VAL(1'b1)) hsync_dly (
        .clk_pix (clk_pix), .arst_n (arst_n), .din (hsync_t), .dout (hsync)
    );
    pipe_delay #(.payload_t(logic), .DEPTH(`GRAPH_LAT), .RESET_VAL(1'b1)) vsync_dly (
        .clk_pix (clk_pix), .arst_n (arst_n), .din (vsync_t), .dout (vsync)
    );

endmodule

// ==== testbench/graph_assertions.sv ====
/*
 * output checks for the graphing display top
 * frame position, blanking colour and hsync window
 */
`include "graph_cfg.svh"

module graph_assertions (
    input logic              clk_pix,
    input logic              arst_n,
    input graph_pkg::coord_t sx,
    input graph_pkg::coord_t sy,
    input logic              hsync,
    input logic              de,
    input logic              frame,
    input graph_pkg::chan_t  red,
    input graph_pkg::chan_t  green,
    input graph_pkg::chan_t  blue
);
    timeunit 1ns;
    timeprecision 1ps;
    import graph_pkg::*;

    localparam int HS_STA = `H_ACTIVE + `H_FP;   // first sync pixel
    localparam int HS_END = HS_STA + `H_SYNC;    // first pixel after sync

    int fail_cnt = 0;  // read by the testbench

    // frame strobe only at the top left pixel
    frame_at_origin: assert property (@(posedge clk_pix) disable iff (!arst_n)
        frame |-> (sx == '0 && sy == '0))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("frame strobe away from origin, sx %h sy %h", sx, sy);
        end

    // blanking is black on all channels
    black_in_blanking: assert property (@(posedge clk_pix) disable iff (!arst_n)
        !de |-> (red == '0 && green == '0 && blue == '0))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("colour outside active area, %h %h %h", red, green, blue);
        end

    // hsync pulse sits inside the sync window
    hsync_in_window: assert property (@(posedge clk_pix) disable iff (!arst_n)
        !hsync |-> (sx >= coord_t'(HS_STA) && sx < coord_t'(HS_END)))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("hsync active at sx %h", sx);
        end

endmodule

// ==== testbench/graph_tb.sv ====
/*
 * testbench for the graphing display top
 * reset state, frame timing, table driven pixels and random colour checks
 */
`include "graph_cfg.svh"

module graph_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import graph_pkg::*;

    localparam int H_TOTAL   = `H_ACTIVE + `H_FP + `H_SYNC + `H_BP;
    localparam int V_TOTAL   = `V_ACTIVE + `V_FP + `V_SYNC + `V_BP;
    localparam int HS_STA    = `H_ACTIVE + `H_FP;   // first hsync pixel
    localparam int HS_END    = HS_STA + `H_SYNC;
    localparam int VS_STA    = `V_ACTIVE + `V_FP;   // first vsync line
    localparam int VS_END    = VS_STA + `V_SYNC;
    localparam int FRAME_CYC = H_TOTAL * V_TOTAL;
    localparam int TIMEOUT   = FRAME_CYC + 1000;  // one frame plus margin
    localparam int N_ENTRIES = 13;
    localparam int AX        = `COL_AXIS;
    localparam int BG        = `COL_BG;

    logic   clk_pix, arst_n;
    coord_t sx, sy;
    logic   hsync, vsync, de, frame;
    chan_t  red, green, blue;

    // sx, sy, red, green, blue in raster order
    // curve rows place sy from the squared rule
    int pix_table [N_ENTRIES][5] = '{
        '{`X_OFFS, 10, AX, AX, AX},                                  // vertical axis
        '{100, 100, BG, BG, BG},
        '{700, 100, 0, 0, 0},                                        // h blanking
        '{`X_OFFS + 20, `Y_OFFS - ((20 * 20) >> `FUNC_SHIFT),
            `COL_CURVE_R, `COL_CURVE_G, `COL_CURVE_B},
        '{`X_OFFS - 16, `Y_OFFS - ((16 * 16) >> `FUNC_SHIFT),
            `COL_CURVE_R, `COL_CURVE_G, `COL_CURVE_B},
        '{`X_OFFS + 12, `Y_OFFS - ((12 * 12) >> `FUNC_SHIFT),
            `COL_CURVE_R, `COL_CURVE_G, `COL_CURVE_B},
        '{`X_OFFS + 8, `Y_OFFS - 3, BG, BG, BG},                     // just off the curve
        '{`X_OFFS + 8, `Y_OFFS - ((8 * 8) >> `FUNC_SHIFT),
            `COL_CURVE_R, `COL_CURVE_G, `COL_CURVE_B},
        '{5, `Y_OFFS, AX, AX, AX},                                   // horizontal axis
        '{`X_OFFS, `Y_OFFS, AX, AX, AX},                             // origin
        '{639, 479, BG, BG, BG},                                     // last active pixel
        '{100, 500, 0, 0, 0},                                        // v blanking
        '{0, 0, BG, BG, BG}
    };

    graph_top dut0 (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .sx      (sx),
        .sy      (sy),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .frame   (frame),
        .red     (red),
        .green   (green),
        .blue    (blue)
    );

    bind graph_top graph_assertions asrt0 (
        .clk_pix (clk_pix), .arst_n (arst_n), .sx (sx), .sy (sy), .hsync (hsync),
        .de (de), .frame (frame), .red (red), .green (green), .blue (blue)
    );

    initial begin
        clk_pix = 1'b0;
        forever #2 clk_pix = ~clk_pix;  // 250 MHz sim clock
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stop_with_failure("value mismatch");
        end
    endtask

    task automatic check_idle();
        check_value("de", de, 0);
        check_value("frame", frame, 0);
        check_value("hsync", hsync, 1);
        check_value("vsync", vsync, 1);
        check_value("red", red, 0);
        check_value("green", green, 0);
        check_value("blue", blue, 0);
    endtask

    // expected colour straight from the drawing rules
    function automatic logic [23:0] colour_of_pixel(input int px, input int py,
                                                    input logic act);
        int fx;
        int fy;
        fx = px - `X_OFFS;
        fy = `Y_OFFS - py;   // y grows upward from the origin
        if (!act) return 24'h0;
        if (px == `X_OFFS || py == `Y_OFFS) return {3{8'(`COL_AXIS)}};
        if (fy >= 0 && ((fx * fx) >> `FUNC_SHIFT) == fy)
            return {8'(`COL_CURVE_R), 8'(`COL_CURVE_G), 8'(`COL_CURVE_B)};
        return {3{8'(`COL_BG)}};
    endfunction

    task automatic wait_for_frame();
        int n;
        n = 0;
        while (frame !== 1'b1) begin
            if (n > TIMEOUT) stop_with_failure("timeout waiting for frame strobe");
            @(negedge clk_pix);
            n++;
        end
    endtask

    task automatic wait_for_pixel(input int px, input int py);
        int n;
        n = 0;
        while (!(sx == coord_t'(px) && sy == coord_t'(py))) begin
            if (n > TIMEOUT)
                stop_with_failure($sformatf("timeout waiting for pixel %0d,%0d", px, py));
            @(negedge clk_pix);
            n++;
        end
    endtask

    // assertion failures end the run right away
    always @(negedge clk_pix) begin
        if (dut0.asrt0.fail_cnt != 0) stop_with_failure("concurrent assertion failed");
    end

    initial begin
        int frames;
        int last_pulse;
        int line_de;
        int lines;
        int gap;
        logic [23:0] exp_rgb;
        void'($urandom(32'h4192866f));
        arst_n <= 1'b0;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk_pix);
            if (i == 3) arst_n <= 1'b1;  // release after 4 edges
            @(negedge clk_pix);
            check_idle();
        end
        @(negedge clk_pix);  // first active edge
        check_idle();

        // one full frame between strobes
        wait_for_frame();
        frames = 0;
        last_pulse = 0;
        lines = 0;
        line_de = de;
        for (int c = 1; c <= FRAME_CYC; c++) begin
            @(negedge clk_pix);
            if (frame) begin
                frames++;
                last_pulse = c;
            end
            // sync levels follow the output position
            check_value("hsync", hsync, !(sx >= HS_STA && sx < HS_END));
            check_value("vsync", vsync, !(sy >= VS_STA && sy < VS_END));
            if (de) line_de++;
            if (sx == coord_t'(H_TOTAL - 1)) begin
                check_value("de per line", line_de, (sy < `V_ACTIVE) ? `H_ACTIVE : 0);
                line_de = 0;
                lines++;
            end
        end
        check_value("frame pulses", frames, 1);
        check_value("frame period", last_pulse, FRAME_CYC);
        check_value("lines per frame", lines, V_TOTAL);

        // table of fixed pixels
        for (int e = 0; e < N_ENTRIES; e++) begin
            wait_for_pixel(pix_table[e][0], pix_table[e][1]);
            check_value("red", red, pix_table[e][2]);
            check_value("green", green, pix_table[e][3]);
            check_value("blue", blue, pix_table[e][4]);
        end

        // random samples spread over the raster
        for (int k = 0; k < 200; k++) begin
            gap = ($urandom % 4096) + 1;
            repeat (gap) @(negedge clk_pix);
            exp_rgb = colour_of_pixel(sx, sy, de);
            check_value("red", red, exp_rgb[23:16]);
            check_value("green", green, exp_rgb[15:8]);
            check_value("blue", blue, exp_rgb[7:0]);
        end

        @(negedge clk_pix);
        if (dut0.asrt0.fail_cnt != 0) begin
            stop_with_failure("concurrent assertion failed");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// ==== graph_top.f ====
+incdir+hdl
hdl/graph_pkg.sv
hdl/pipe_delay.sv
hdl/display_timing.sv
hdl/func_squared.sv
hdl/graph_plotter.sv
hdl/graph_top.sv
testbench/graph_assertions.sv
testbench/graph_tb.sv
